// ==== common/dcache_pkg.sv ====
package dcache_pkg;

	// request and bus data widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	// one sram word holds two bus beats
	localparam int LINE_W = 2 * DATA_W;
	localparam int STRB_W = DATA_W / 8;

	// address split: tag | index | word | half | byte
	localparam int TAG_W = 22;
	localparam int INDEX_W = 4;
	localparam int WORD_SEL_W = 2;
	localparam int TAG_LSB = 10;
	localparam int INDEX_LSB = 6;
	localparam int WORD_LSB = 4;
	// picks the 64-bit half inside a 128-bit word
	localparam int HALF_BIT = 3;

	// 16 sets, each line is four sram words
	localparam int SETS = 1 << INDEX_W;
	localparam int SRAM_AW = INDEX_W + WORD_SEL_W;
	localparam int SRAM_DEPTH = 1 << SRAM_AW;

	// associativity, hit and victim vectors are one-hot over this
	localparam int WAYS = 4;

	// axi4 field widths
	localparam int AXI_LEN_W = 8;
	localparam int AXI_SIZE_W = 3;
	localparam int AXI_BURST_W = 2;
	localparam int AXI_RESP_W = 2;

	// refill is eight beats, len code is beats minus one
	localparam logic [AXI_LEN_W-1:0] BURST_LEN = 8'd7;
	// eight bytes per beat
	localparam logic [AXI_SIZE_W-1:0] AXI_SIZE_8B = 3'd3;
	localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'd1;
	localparam logic [AXI_RESP_W-1:0] AXI_RESP_OKAY = 2'd0;

endpackage

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl #(
	parameter logic [dcache_pkg::ADDR_W-1:0] CACHED_LIMIT = 32'h8fff_ffff
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              valid,
	output logic                              ready,
	input  logic [dcache_pkg::ADDR_W-1:0]     addr,
	input  logic                              wren,
	input  logic [dcache_pkg::DATA_W-1:0]     mask,
	input  logic [dcache_pkg::WAYS-1:0]       way_hit,
	output logic [dcache_pkg::ADDR_W-1:0]     araddr,
	output logic [dcache_pkg::AXI_LEN_W-1:0]  arlen,
	output logic                              arvalid,
	input  logic                              arready,
	input  logic [dcache_pkg::AXI_RESP_W-1:0] rresp,
	input  logic                              rlast,
	input  logic                              rvalid,
	output logic [dcache_pkg::ADDR_W-1:0]     awaddr,
	output logic                              awvalid,
	input  logic                              awready,
	output logic [dcache_pkg::STRB_W-1:0]     wstrb,
	output logic                              wlast,
	output logic                              wvalid,
	input  logic                              wready,
	input  logic [dcache_pkg::AXI_RESP_W-1:0] bresp,
	input  logic                              bvalid,
	output logic                              lookup,
	output logic                              beat,
	output logic                              store,
	output logic                              install,
	output logic                              uncached_hit_data_sel
);

	localparam logic [2:0] S_IDLE     = 3'd0;
	localparam logic [2:0] S_RD_BURST = 3'd1;
	localparam logic [2:0] S_SETTLE   = 3'd2;
	localparam logic [2:0] S_WR_ADDR  = 3'd3;
	localparam logic [2:0] S_WR_DATA  = 3'd4;
	localparam logic [2:0] S_WR_RESP  = 3'd5;
	localparam logic [2:0] S_UC_READ  = 3'd6;

	logic [2:0] state;
	logic [2:0] state_nxt;
	logic       ready_nxt;
	logic       cached;
	logic       accept;
	logic       hit;

	// everything above the limit is device space
	assign cached = addr <= CACHED_LIMIT;
	assign hit    = |way_hit;
	// ready blocks the held request from starting twice
	assign accept = (state == S_IDLE) && valid && !ready;

	assign lookup  = accept && cached;
	// write-through, sram only updated on a hit
	assign store   = lookup && wren && hit;
	assign beat    = (state == S_RD_BURST) && rvalid;
	assign install = beat && rlast;

	// refill asks for the whole line, device reads one beat at the exact address
	assign araddr  = cached
		? {addr[dcache_pkg::ADDR_W-1:dcache_pkg::INDEX_LSB], {dcache_pkg::INDEX_LSB{1'b0}}}
		: addr;
	assign arlen   = cached ? dcache_pkg::BURST_LEN : '0;
	// read miss or device read, held in idle until arready
	assign arvalid = accept && !wren && !(cached && hit);

	assign awaddr  = addr;
	assign awvalid = (state == S_WR_ADDR);
	// single-beat write, so every beat is the last
	assign wvalid  = (state == S_WR_DATA);
	assign wlast   = wvalid;

	// one mask bit per byte lane is enough
	always_comb begin
		for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
			wstrb[b] = mask[8*b];
		end
	end

	always_comb begin
		state_nxt = state;
		ready_nxt = 1'b0;
		case (state)
			S_IDLE: begin
				if (accept && wren) begin
					state_nxt = S_WR_ADDR;
				end else if (arvalid && arready) begin
					state_nxt = cached ? S_RD_BURST : S_UC_READ;
				end else if (lookup && hit) begin
					// read hit, data comes out of the sram next cycle
					ready_nxt = 1'b1;
				end
			end
			S_RD_BURST: begin
				if (install) state_nxt = S_SETTLE;
			end
			// one idle cycle before the repeated lookup
			S_SETTLE: state_nxt = S_IDLE;
			S_UC_READ: begin
				if (rvalid) begin
					state_nxt = S_IDLE;
					ready_nxt = 1'b1;
				end
			end
			S_WR_ADDR: begin
				if (awready) state_nxt = S_WR_DATA;
			end
			S_WR_DATA: begin
				if (wready) state_nxt = S_WR_RESP;
			end
			S_WR_RESP: begin
				if (bvalid) begin
					state_nxt = S_IDLE;
					ready_nxt = 1'b1;
				end
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state                 <= S_IDLE;
			ready                 <= 1'b0;
			uncached_hit_data_sel <= 1'b0;
		end else begin
			state                 <= state_nxt;
			ready                 <= ready_nxt;
			// steer dout to the held rdata in the ready cycle
			uncached_hit_data_sel <= (state == S_UC_READ) && rvalid;
		end
	end

	// a stalled write keeps its address and strobes
	a_wr_hold: assert property (@(posedge clk) disable iff (rst)
		(awvalid && !awready) || (wvalid && !wready) |=> $stable(awaddr) && $stable(wstrb));
	// requester holds its request, so a stalled AR stays put
	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));
	// no error recovery
	a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
		rvalid |-> rresp == dcache_pkg::AXI_RESP_OKAY);
	a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
		bvalid |-> bresp == dcache_pkg::AXI_RESP_OKAY);

endmodule

// ==== design/dcache_tag_array.sv ====
`timescale 1ns/1ps

module dcache_tag_array (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [dcache_pkg::ADDR_W-1:0] addr,
	input  logic                          lookup,
	input  logic                          install,
	output logic [dcache_pkg::WAYS-1:0]   way_hit,
	output logic [dcache_pkg::WAYS-1:0]   way_sel
);

	logic [dcache_pkg::TAG_W-1:0]   tags [dcache_pkg::WAYS][dcache_pkg::SETS];
	logic [dcache_pkg::SETS-1:0]    vld [dcache_pkg::WAYS];
	// one-hot replacement pointer
	logic [dcache_pkg::WAYS-1:0]    victim;
	logic [dcache_pkg::INDEX_W-1:0] index;
	logic [dcache_pkg::TAG_W-1:0]   tag;

	assign index = addr[dcache_pkg::INDEX_LSB +: dcache_pkg::INDEX_W];
	assign tag   = addr[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_W];

	always_comb begin
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			way_hit[w] = vld[w][index] && (tags[w][index] == tag);
		end
	end

	// on a miss the refill path writes into the victim
	assign way_sel = (|way_hit) ? way_hit : victim;

	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= dcache_pkg::WAYS'(1);
			for (int w = 0; w < dcache_pkg::WAYS; w++) begin
				vld[w] <= '0;
				for (int s = 0; s < dcache_pkg::SETS; s++) begin
					tags[w][s] <= '0;
				end
			end
		end else begin
			// pointer only moves in idle, so it is frozen across a refill
			if (lookup) begin
				victim <= {victim[dcache_pkg::WAYS-2:0], victim[dcache_pkg::WAYS-1]};
			end
			// tag goes in with the last beat
			if (install) begin
				for (int w = 0; w < dcache_pkg::WAYS; w++) begin
					if (victim[w]) begin
						vld[w][index]  <= 1'b1;
						tags[w][index] <= tag;
					end
				end
			end
		end
	end

	a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(way_hit));
	// the refilled line hits in the way the data went to
	a_install_hits: assert property (@(posedge clk) disable iff (rst)
		install |=> way_hit == $past(victim));

endmodule

// ==== design/dcache_refill.sv ====
`timescale 1ns/1ps

module dcache_refill (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [dcache_pkg::ADDR_W-1:0]  addr,
	input  logic [dcache_pkg::DATA_W-1:0]  din,
	input  logic [dcache_pkg::DATA_W-1:0]  mask,
	input  logic [dcache_pkg::DATA_W-1:0]  rdata,
	input  logic                           lookup,
	input  logic                           beat,
	input  logic                           store,
	input  logic [dcache_pkg::WAYS-1:0]    way_sel,
	output logic [dcache_pkg::WAYS-1:0]    cen,
	output logic                           wen,
	output logic [dcache_pkg::LINE_W-1:0]  bwen,
	output logic [dcache_pkg::SRAM_AW-1:0] sram_addr,
	output logic [dcache_pkg::LINE_W-1:0]  sram_din,
	output logic [dcache_pkg::DATA_W-1:0]  rdata_hold
);

	// low bit is the half, upper bits the word within the line
	logic [dcache_pkg::WORD_SEL_W:0]  cnt;
	logic                             half;
	logic [dcache_pkg::DATA_W-1:0]    half_bwen;
	logic [dcache_pkg::DATA_W-1:0]    wr_data;
	logic [dcache_pkg::INDEX_W-1:0]   index;

	assign index = addr[dcache_pkg::INDEX_LSB +: dcache_pkg::INDEX_W];

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (lookup) begin
			// every request starts with a lookup, so a burst starts at zero
			cnt <= '0;
		end else if (beat) begin
			cnt <= cnt + 1'b1;
		end
	end

	// device read data must outlive the rvalid cycle
	always_ff @(posedge clk) begin
		rdata_hold <= rdata;
	end

	assign wr_data = beat ? rdata : din;
	assign half    = beat ? cnt[0] : addr[dcache_pkg::HALF_BIT];
	// active low, a refill beat writes the whole half
	assign half_bwen = beat ? '0 : ~mask;
	assign bwen = half
		? {half_bwen, {dcache_pkg::DATA_W{1'b1}}}
		: {{dcache_pkg::DATA_W{1'b1}}, half_bwen};
	// both halves carry the data, bwen picks the one written
	assign sram_din = {wr_data, wr_data};

	assign sram_addr = beat
		? {index, cnt[dcache_pkg::WORD_SEL_W:1]}
		: {index, addr[dcache_pkg::WORD_LSB +: dcache_pkg::WORD_SEL_W]};

	// store only ever comes with a lookup
	assign wen = beat || store;
	assign cen = way_sel & {dcache_pkg::WAYS{beat || lookup}};

endmodule

// ==== design/dcache_data_array.sv ====
`timescale 1ns/1ps

module dcache_data_array (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [dcache_pkg::WAYS-1:0]    cen,
	input  logic                           wen,
	input  logic [dcache_pkg::LINE_W-1:0]  bwen,
	input  logic [dcache_pkg::SRAM_AW-1:0] sram_addr,
	input  logic [dcache_pkg::LINE_W-1:0]  sram_din,
	input  logic                           half_sel,
	input  logic [dcache_pkg::WAYS-1:0]    way_hit,
	output logic [dcache_pkg::DATA_W-1:0]  dout
);

	// read word of each way, zeroed unless that way hit last cycle
	logic [dcache_pkg::LINE_W-1:0] masked [dcache_pkg::WAYS];
	logic [dcache_pkg::WAYS-1:0]   hit_q;
	logic [dcache_pkg::LINE_W-1:0] line;

	for (genvar w = 0; w < dcache_pkg::WAYS; w++) begin : g_way
		logic [dcache_pkg::LINE_W-1:0] mem [dcache_pkg::SRAM_DEPTH];
		logic [dcache_pkg::LINE_W-1:0] rd_q;

		// single port, bwen low means write that bit
		always_ff @(posedge clk) begin
			if (cen[w]) begin
				if (wen) begin
					mem[sram_addr] <= (mem[sram_addr] & bwen) | (sram_din & ~bwen);
				end else begin
					rd_q <= mem[sram_addr];
				end
			end
		end

		assign masked[w] = rd_q & {dcache_pkg::LINE_W{hit_q[w]}};
	end

	// read data lands one cycle after the lookup
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q <= '0;
		end else begin
			hit_q <= way_hit;
		end
	end

	// hit is one-hot so an or of masked words is the mux
	always_comb begin
		line = '0;
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			line = line | masked[w];
		end
	end

	// request address is still held in the ready cycle
	assign dout = half_sel
		? line[dcache_pkg::LINE_W-1:dcache_pkg::DATA_W]
		: line[dcache_pkg::DATA_W-1:0];

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
	parameter logic [dcache_pkg::ADDR_W-1:0] CACHED_LIMIT = 32'h8fff_ffff
) (
	input  logic                                clk,
	input  logic                                rst,
	// request port from the memory stage
	input  logic                                valid,
	output logic                                ready,
	input  logic [dcache_pkg::ADDR_W-1:0]       addr,
	input  logic                                wren,
	input  logic [dcache_pkg::DATA_W-1:0]       din,
	input  logic [dcache_pkg::DATA_W-1:0]       mask,
	output logic [dcache_pkg::DATA_W-1:0]       dout,
	// axi read address and data
	output logic [dcache_pkg::ADDR_W-1:0]       araddr,
	output logic [dcache_pkg::AXI_LEN_W-1:0]    arlen,
	output logic [dcache_pkg::AXI_SIZE_W-1:0]   arsize,
	output logic [dcache_pkg::AXI_BURST_W-1:0]  arburst,
	output logic                                arvalid,
	input  logic                                arready,
	input  logic [dcache_pkg::DATA_W-1:0]       rdata,
	input  logic [dcache_pkg::AXI_RESP_W-1:0]   rresp,
	input  logic                                rlast,
	input  logic                                rvalid,
	output logic                                rready,
	// axi write address, data and response
	output logic [dcache_pkg::ADDR_W-1:0]       awaddr,
	output logic [dcache_pkg::AXI_LEN_W-1:0]    awlen,
	output logic [dcache_pkg::AXI_SIZE_W-1:0]   awsize,
	output logic [dcache_pkg::AXI_BURST_W-1:0]  awburst,
	output logic                                awvalid,
	input  logic                                awready,
	output logic [dcache_pkg::DATA_W-1:0]       wdata,
	output logic [dcache_pkg::STRB_W-1:0]       wstrb,
	output logic                                wlast,
	output logic                                wvalid,
	input  logic                                wready,
	input  logic [dcache_pkg::AXI_RESP_W-1:0]   bresp,
	input  logic                                bvalid,
	output logic                                bready
);

	logic [dcache_pkg::WAYS-1:0]    way_hit;
	logic [dcache_pkg::WAYS-1:0]    way_sel;
	logic                           lookup;
	logic                           beat;
	logic                           store;
	logic                           install;
	logic                           uncached_hit_data_sel;
	logic [dcache_pkg::WAYS-1:0]    cen;
	logic                           wen;
	logic [dcache_pkg::LINE_W-1:0]  bwen;
	logic [dcache_pkg::SRAM_AW-1:0] sram_addr;
	logic [dcache_pkg::LINE_W-1:0]  sram_din;
	logic [dcache_pkg::DATA_W-1:0]  hit_dout;
	logic [dcache_pkg::DATA_W-1:0]  rdata_hold;

	// fixed burst shape, one outstanding transaction at a time
	assign arsize  = dcache_pkg::AXI_SIZE_8B;
	assign arburst = dcache_pkg::AXI_BURST_INCR;
	assign awlen   = '0;
	assign awsize  = dcache_pkg::AXI_SIZE_8B;
	assign awburst = dcache_pkg::AXI_BURST_INCR;
	// cache always sinks R beats and B responses
	assign rready  = 1'b1;
	assign bready  = 1'b1;
	// store data goes out unchanged, strobes come from ctrl
	assign wdata   = din;

	// uncached reads bypass the arrays
	assign dout = uncached_hit_data_sel ? rdata_hold : hit_dout;

	dcache_ctrl #(
		.CACHED_LIMIT(CACHED_LIMIT)
	) dcache_ctrl_inst (
		.clk, .rst, .valid, .ready, .addr, .wren, .mask, .way_hit,
		.araddr, .arlen, .arvalid, .arready, .rresp, .rlast, .rvalid,
		.awaddr, .awvalid, .awready, .wstrb, .wlast, .wvalid, .wready,
		.bresp, .bvalid,
		.lookup, .beat, .store, .install, .uncached_hit_data_sel
	);

	dcache_tag_array dcache_tag_array_inst (
		.clk, .rst, .addr, .lookup, .install, .way_hit, .way_sel
	);

	dcache_refill dcache_refill_inst (
		.clk, .rst, .addr, .din, .mask, .rdata, .lookup, .beat, .store, .way_sel,
		.cen, .wen, .bwen, .sram_addr, .sram_din, .rdata_hold
	);

	dcache_data_array dcache_data_array_inst (
		.clk, .rst, .cen, .wen, .bwen, .sram_addr, .sram_din,
		.half_sel(addr[dcache_pkg::HALF_BIT]),
		.way_hit,
		.dout(hit_dout)
	);

endmodule

// ==== sim/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] araddr,
	input  logic [7:0]  arlen,
	input  logic        arvalid,
	output logic        arready,
	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rlast,
	output logic        rvalid,
	input  logic        rready,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [63:0] wdata,
	input  logic [7:0]  wstrb,
	input  logic        wlast,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready
);

	// sparse store keyed by 64-bit word address
	logic [63:0] mem [logic [28:0]];
	integer      seed = 32'h649729a0;
	logic [28:0] rd_word;
	logic [7:0]  rd_left;
	logic [28:0] wr_word;
	logic [63:0] merged;

	// never-written words read as their own byte address with a marker on top
	function automatic logic [63:0] load(input logic [28:0] word);
		if (mem.exists(word)) begin
			return mem[word];
		end else begin
			return 64'h5a5a_0000_0000_0000 | 64'({word, 3'b000});
		end
	endfunction

	assign rresp = 2'b00;
	assign bresp = 2'b00;

	initial begin
		arready <= 1'b0;
		awready <= 1'b0;
		wready  <= 1'b0;
		rvalid  <= 1'b0;
		rlast   <= 1'b0;
		rdata   <= '0;
		bvalid  <= 1'b0;
	end

	always @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;
			rvalid  <= 1'b0;
			rlast   <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			// each ready drops about one cycle in four
			arready <= ($random(seed) & 3) != 0;
			awready <= ($random(seed) & 3) != 0;
			wready  <= ($random(seed) & 3) != 0;
			// incrementing burst, beats back to back
			if (!rvalid && arvalid && arready) begin
				rvalid  <= 1'b1;
				rdata   <= load(araddr[31:3]);
				rlast   <= (arlen == 8'd0);
				rd_word <= araddr[31:3] + 29'd1;
				rd_left <= arlen;
			end else if (rvalid && rready) begin
				if (rlast) begin
					rvalid <= 1'b0;
					rlast  <= 1'b0;
				end else begin
					rdata   <= load(rd_word);
					rlast   <= (rd_left == 8'd1);
					rd_word <= rd_word + 29'd1;
					rd_left <= rd_left - 8'd1;
				end
			end
			if (awvalid && awready) begin
				wr_word <= awaddr[31:3];
			end
			// byte lanes merge into the current word
			if (wvalid && wready) begin
				merged = load(wr_word);
				for (int b = 0; b < 8; b++) begin
					if (wstrb[b]) begin
						merged[8*b +: 8] = wdata[8*b +: 8];
					end
				end
				mem[wr_word] = merged;
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

endmodule

// ==== sim/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;

	localparam logic [dcache_pkg::ADDR_W-1:0] CACHED_LIMIT = 32'h8fff_ffff;
	// op, addr, store data, bit mask, expected read
	localparam int FIELDS = 5;
	localparam int MAX_REQ = 64;
	localparam int TIMEOUT_CYCLES = 200;

	// first golden column
	localparam logic [7:0] OP_READ_HIT  = 8'h00;
	localparam logic [7:0] OP_READ_MISS = 8'h01;
	localparam logic [7:0] OP_READ_ANY  = 8'h02;
	localparam logic [7:0] OP_WRITE     = 8'h03;
	localparam logic [7:0] OP_MEM_CHECK = 8'h04;
	localparam logic [7:0] OP_END       = 8'hff;

	logic                                clk;
	logic                                rst;
	logic                                valid;
	logic                                ready;
	logic [dcache_pkg::ADDR_W-1:0]       addr;
	logic                                wren;
	logic [dcache_pkg::DATA_W-1:0]       din;
	logic [dcache_pkg::DATA_W-1:0]       mask;
	logic [dcache_pkg::DATA_W-1:0]       dout;
	logic [dcache_pkg::ADDR_W-1:0]       araddr;
	logic [dcache_pkg::AXI_LEN_W-1:0]    arlen;
	logic [dcache_pkg::AXI_SIZE_W-1:0]   arsize;
	logic [dcache_pkg::AXI_BURST_W-1:0]  arburst;
	logic                                arvalid;
	logic                                arready;
	logic [dcache_pkg::DATA_W-1:0]       rdata;
	logic [dcache_pkg::AXI_RESP_W-1:0]   rresp;
	logic                                rlast;
	logic                                rvalid;
	logic                                rready;
	logic [dcache_pkg::ADDR_W-1:0]       awaddr;
	logic [dcache_pkg::AXI_LEN_W-1:0]    awlen;
	logic [dcache_pkg::AXI_SIZE_W-1:0]   awsize;
	logic [dcache_pkg::AXI_BURST_W-1:0]  awburst;
	logic                                awvalid;
	logic                                awready;
	logic [dcache_pkg::DATA_W-1:0]       wdata;
	logic [dcache_pkg::STRB_W-1:0]       wstrb;
	logic                                wlast;
	logic                                wvalid;
	logic                                wready;
	logic [dcache_pkg::AXI_RESP_W-1:0]   bresp;
	logic                                bvalid;
	logic                                bready;

	logic [63:0]                         golden [FIELDS*MAX_REQ];
	// AR handshakes seen so far and the length of the latest one
	int                                  ar_total;
	logic [dcache_pkg::AXI_LEN_W-1:0]    ar_len_seen;

	dcache_top #(
		.CACHED_LIMIT(CACHED_LIMIT)
	) dcache_top_inst (
		.clk, .rst, .valid, .ready, .addr, .wren, .din, .mask, .dout,
		.araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
		.rdata, .rresp, .rlast, .rvalid, .rready,
		.awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
		.wdata, .wstrb, .wlast, .wvalid, .wready, .bresp, .bvalid, .bready
	);

	axi_mem_model axi_mem_model_inst (
		.clk, .rst, .araddr, .arlen, .arvalid, .arready,
		.rdata, .rresp, .rlast, .rvalid, .rready,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wlast, .wvalid, .wready,
		.bresp, .bvalid, .bready
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic stop_run();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic compare_data(input string name,
			input logic [dcache_pkg::DATA_W-1:0] expected,
			input logic [dcache_pkg::DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic compare_len(input string name,
			input logic [dcache_pkg::AXI_LEN_W-1:0] expected,
			input logic [dcache_pkg::AXI_LEN_W-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic compare_size(input string name,
			input logic [dcache_pkg::AXI_SIZE_W-1:0] expected,
			input logic [dcache_pkg::AXI_SIZE_W-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic compare_burst(input string name,
			input logic [dcache_pkg::AXI_BURST_W-1:0] expected,
			input logic [dcache_pkg::AXI_BURST_W-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic compare_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
			stop_run();
		end
	endtask

	// handshake values are stable at the falling edge
	always @(negedge clk) begin
		if (rst) begin
			ar_total <= 0;
		end else begin
			if (arvalid && arready) begin
				ar_total    <= ar_total + 1;
				ar_len_seen <= arlen;
				// eight-byte beats on an incrementing burst
				compare_size("arsize", 3'd3, arsize);
				compare_burst("arburst", 2'd1, arburst);
			end
			if (awvalid && awready) begin
				// every write is a single beat
				compare_len("awlen", 8'd0, awlen);
				compare_size("awsize", 3'd3, awsize);
				compare_burst("awburst", 2'd1, awburst);
			end
			if (wvalid && wready) begin
				compare_flag("wlast", 1'b1, wlast);
			end
		end
	end

	// a refill fetches the whole 64-byte line in eight beats, device space one beat
	function automatic logic [dcache_pkg::AXI_LEN_W-1:0] expected_len(
			input logic [dcache_pkg::ADDR_W-1:0] a);
		if (a <= CACHED_LIMIT) begin
			return 8'd7;
		end else begin
			return 8'd0;
		end
	endfunction

	task automatic wait_ready(input int n);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!ready) begin
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("request %0d got no ready within %0d cycles", n, TIMEOUT_CYCLES);
				stop_run();
			end
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic check_ar_traffic(input logic [7:0] op,
			input logic [dcache_pkg::ADDR_W-1:0] a, input int count);
		if ((op == OP_READ_HIT || op == OP_WRITE) && count != 0) begin
			$display("request at %h sent %0d AR requests where none were due", a, count);
			stop_run();
		end
		if (op == OP_READ_MISS) begin
			if (count != 1) begin
				$display("read at %h sent %0d AR requests instead of one", a, count);
				stop_run();
			end
			compare_len("arlen", expected_len(a), ar_len_seen);
		end
		// either a hit or a single refill
		if (op == OP_READ_ANY && count > 1) begin
			$display("read at %h sent %0d AR requests", a, count);
			stop_run();
		end
	endtask

	task automatic run_request(input int n);
		logic [7:0]                    op;
		logic [dcache_pkg::ADDR_W-1:0] a;
		logic [dcache_pkg::DATA_W-1:0] expected;
		int                            ar_before;
		op       = golden[FIELDS*n][7:0];
		a        = golden[FIELDS*n+1][dcache_pkg::ADDR_W-1:0];
		expected = golden[FIELDS*n+4];
		if (op == OP_MEM_CHECK) begin
			// write-through has finished once ready came back
			compare_data("memory", expected, axi_mem_model_inst.mem[a[31:3]]);
		end else begin
			ar_before = ar_total;
			@(posedge clk);
			valid <= 1'b1;
			addr  <= a;
			wren  <= (op == OP_WRITE);
			din   <= golden[FIELDS*n+2];
			mask  <= golden[FIELDS*n+3];
			wait_ready(n);
			if (op != OP_WRITE) begin
				compare_data("dout", expected, dout);
			end
			check_ar_traffic(op, a, ar_total - ar_before);
			@(posedge clk);
			valid <= 1'b0;
		end
	endtask

	initial begin
		int n;
		for (int i = 0; i < FIELDS*MAX_REQ; i++) begin
			golden[i] = 64'hff;
		end
		rst   <= 1'b1;
		valid <= 1'b0;
		addr  <= '0;
		wren  <= 1'b0;
		din   <= '0;
		mask  <= '0;
		$readmemh("sim/dcache_golden.txt", golden);
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		n = 0;
		while (n < MAX_REQ && golden[FIELDS*n][7:0] != OP_END) begin
			run_request(n);
			n++;
		end
		if (n == 0) begin
			$display("no requests found in the golden file");
			stop_run();
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// ==== sim/dcache_golden.txt ====
// columns: op addr store_data bit_mask expected_read, all hex, one request per line
// op 0 read that hits, 1 read that misses, 2 read either way, 3 write, 4 memory check, ff end
1 00001040 0 0 5a5a000000001040
0 00001040 0 0 5a5a000000001040
0 00001048 0 0 5a5a000000001048
0 00001070 0 0 5a5a000000001070
3 00001050 1122334455667788 0000ffff0000ff00 0
0 00001050 0 0 5a5a334400007750
4 00001050 0 0 5a5a334400007750
0 00001058 0 0 5a5a000000001058
3 00002208 deadbeefcafef00d ffffffff00000000 0
4 00002208 0 0 deadbeef00002208
1 00002208 0 0 deadbeef00002208
0 00002200 0 0 5a5a000000002200
1 00000148 0 0 5a5a000000000148
0 00000148 0 0 5a5a000000000148
1 00000558 0 0 5a5a000000000558
0 00000558 0 0 5a5a000000000558
1 00000960 0 0 5a5a000000000960
0 00000960 0 0 5a5a000000000960
1 00000d78 0 0 5a5a000000000d78
0 00000d78 0 0 5a5a000000000d78
1 00001140 0 0 5a5a000000001140
0 00001140 0 0 5a5a000000001140
2 00000148 0 0 5a5a000000000148
2 00000558 0 0 5a5a000000000558
2 00000960 0 0 5a5a000000000960
2 00000d78 0 0 5a5a000000000d78
2 00001140 0 0 5a5a000000001140
1 8ffffff8 0 0 5a5a00008ffffff8
0 8ffffff0 0 0 5a5a00008ffffff0
1 90000000 0 0 5a5a000090000000
1 a0000010 0 0 5a5a0000a0000010
3 a0000010 0123456789abcdef ffffffffffffffff 0
1 a0000010 0 0 0123456789abcdef
3 a0000010 ffffffffffffffff 00000000000000ff 0
1 a0000010 0 0 0123456789abcdff
4 a0000010 0 0 0123456789abcdff
ff 0 0 0 0

// ==== all.f ====
common/dcache_pkg.sv
design/dcache_ctrl.sv
design/dcache_tag_array.sv
design/dcache_refill.sv
design/dcache_data_array.sv
design/dcache_top.sv
sim/axi_mem_model.sv
sim/tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= tb_dcache
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "run ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
